// File: filelist.f
+incdir+testbench
hdl/fp_format_pkg.sv
hdl/fpu_op_pkg.sv
hdl/fp_operand_unpack.sv
hdl/fp_classify.sv
hdl/fp_sign_inject.sv
hdl/fp_min_max.sv
hdl/fp_misc_unit.sv
testbench/tb_fp_misc_unit.sv

// File: testbench/tb_fp_misc_tasks.svh
task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                           input string message);
    check_count++;
    if (actual !== expected)
    begin
        $display("Mismatch at %0t ns: %s: got %h, expected %h", $time, message,
                 actual, expected);
        mismatch_count++;
    end
endtask

// Called 5 ns after a rising edge and returns at the same phase.
task automatic do_request(input fpu_op_pkg::fpu_req_t request,
                          output fpu_op_pkg::fpu_rsp_t response);
    req_data = request;
    req = 1'b1;
    @(posedge clk);
    #5;
    while (!ack)
    begin
        @(posedge clk);
        #5;
    end
    response = rsp_data;
    req = 1'b0;
    while (ack)
    begin
        @(posedge clk);
        #5;
    end
endtask

task automatic send_op(input fpu_op_pkg::fp_op_e op, input fpu_op_pkg::fp_prec_e prec,
                       input fp_format_pkg::fp_word_t rs1, input fp_format_pkg::fp_word_t rs2,
                       output fpu_op_pkg::fpu_rsp_t response);
    fpu_op_pkg::fpu_req_t request;
    request.op = op;
    request.prec = prec;
    request.rs1 = rs1;
    request.rs2 = rs2;
    do_request(request, response);
endtask

task automatic test_handshake();
    fpu_op_pkg::fpu_req_t request;
    fpu_op_pkg::fpu_rsp_t held;
    int                   edges;
    check_value(ack, 1'b0, "ack after reset");
    check_value(rsp_data, '0, "rsp_data after reset");
    request.op = fpu_op_pkg::OP_FSGNJN;
    request.prec = fpu_op_pkg::PREC_DOUBLE;
    request.rs1 = 64'h3FF0_0000_0000_0000;
    request.rs2 = '0;
    req_data = request;
    req = 1'b1;
    edges = 0;
    while (!ack && edges < 10)
    begin
        @(posedge clk);
        #5;
        edges++;
    end
    check_value(edges, 2, "edges from req to ack");
    held = rsp_data;
    check_value(held.result, 64'hBFF0_0000_0000_0000, "FSGNJN result under hold");
    repeat (10)
    begin
        @(posedge clk);
        #5;
        check_value(ack, 1'b1, "ack while req held high");
        check_value(rsp_data, held, "rsp_data while req held high");
    end
    req = 1'b0;
    @(posedge clk);
    #5;
    check_value(ack, 1'b0, "ack one edge after req falls");
endtask

// Hand-built operand of one class; NaNs carry a clear sign bit.
function automatic fp_format_pkg::fp_word_t class_sample(input int cls, input logic single);
    logic                    sign;
    fp_format_pkg::fp_exp_t  exponent;
    fp_format_pkg::fp_frac_t frac;
    fp_format_pkg::fp_word_t word;
    sign = (cls <= fp_format_pkg::CLASS_NEG_ZERO);    // Classes 0 to 3 are negative.
    exponent = '0;
    frac = '0;
    case (cls)
        fp_format_pkg::CLASS_NEG_INF, fp_format_pkg::CLASS_POS_INF:
            exponent = '1;
        fp_format_pkg::CLASS_NEG_NORMAL, fp_format_pkg::CLASS_POS_NORMAL:
            exponent = 11'd1;
        fp_format_pkg::CLASS_NEG_SUBNORMAL, fp_format_pkg::CLASS_POS_SUBNORMAL:
            frac = 52'd1;
        fp_format_pkg::CLASS_SNAN:
        begin
            exponent = '1;
            frac = 52'd1;
        end
        fp_format_pkg::CLASS_QNAN:
        begin
            exponent = '1;
            frac = single ? 52'h40_0000 : 52'h8_0000_0000_0000; // Quiet bit only.
        end
        default:
            exponent = '0;
    endcase
    if (single)
        word = {32'hFFFF_FFFF, sign, exponent[7:0], frac[22:0]};
    else
        word = {sign, exponent, frac};
    return word;
endfunction

task automatic test_classification();
    fpu_op_pkg::fpu_rsp_t response;
    int                   cls;
    for (cls = 0; cls < 10; cls++)
    begin
        send_op(fpu_op_pkg::OP_FCLASS, fpu_op_pkg::PREC_SINGLE, class_sample(cls, 1'b1),
                '0, response);
        check_value(response.result, 64'd1 << cls, $sformatf("FCLASS single class %0d", cls));
        check_value(response.nv, 1'b0, $sformatf("nv of FCLASS single class %0d", cls));
        send_op(fpu_op_pkg::OP_FCLASS, fpu_op_pkg::PREC_DOUBLE, class_sample(cls, 1'b0),
                '0, response);
        check_value(response.result, 64'd1 << cls, $sformatf("FCLASS double class %0d", cls));
        check_value(response.nv, 1'b0, $sformatf("nv of FCLASS double class %0d", cls));
    end
endtask

task automatic test_nan_boxing();
    fpu_op_pkg::fpu_rsp_t response;
    send_op(fpu_op_pkg::OP_FCLASS, fpu_op_pkg::PREC_SINGLE, 64'h0000_0000_3F80_0000,
            '0, response);
    check_value(response.result, 64'd1 << fp_format_pkg::CLASS_QNAN, "FCLASS unboxed single");
    send_op(fpu_op_pkg::OP_FSGNJ, fpu_op_pkg::PREC_SINGLE, 64'hFFFF_FFFF_3F80_0000,
            64'hFFFF_FFFF_C000_0000, response);
    check_value(response.result[63:32], 32'hFFFF_FFFF, "FSGNJ single upper half");
    check_value(response.result, 64'hFFFF_FFFF_BF80_0000, "FSGNJ single value");
endtask

task automatic test_sign_injection();
    fpu_op_pkg::fpu_rsp_t    response;
    fp_format_pkg::fp_word_t a;
    fp_format_pkg::fp_word_t b;
    int                      i;
    for (i = 0; i < 20; i++)
    begin
        random_word(a);
        random_word(b);
        send_op(fpu_op_pkg::OP_FSGNJ, fpu_op_pkg::PREC_DOUBLE, a, b, response);
        check_value(response.result, {b[63], a[62:0]}, $sformatf("FSGNJ pair %0d", i));
        send_op(fpu_op_pkg::OP_FSGNJN, fpu_op_pkg::PREC_DOUBLE, a, b, response);
        check_value(response.result, {~b[63], a[62:0]}, $sformatf("FSGNJN pair %0d", i));
        send_op(fpu_op_pkg::OP_FSGNJX, fpu_op_pkg::PREC_DOUBLE, a, b, response);
        check_value(response.result, {a[63] ^ b[63], a[62:0]},
                    $sformatf("FSGNJX pair %0d", i));
    end
endtask

task automatic minmax_case(input fpu_op_pkg::fp_op_e op, input fpu_op_pkg::fp_prec_e prec,
                           input fp_format_pkg::fp_word_t rs1,
                           input fp_format_pkg::fp_word_t rs2,
                           input fp_format_pkg::fp_word_t expected, input logic expected_nv);
    fpu_op_pkg::fpu_rsp_t response;
    send_op(op, prec, rs1, rs2, response);
    check_value(response.result, expected, $sformatf("%s of %h and %h", op.name(), rs1, rs2));
    check_value(response.nv, expected_nv, $sformatf("nv of %h and %h", rs1, rs2));
endtask

task automatic test_min_max();
    fpu_op_pkg::fp_op_e   fmin;
    fpu_op_pkg::fp_op_e   fmax;
    fpu_op_pkg::fp_prec_e sp;
    fpu_op_pkg::fp_prec_e dp;
    fmin = fpu_op_pkg::OP_FMIN;
    fmax = fpu_op_pkg::OP_FMAX;
    sp = fpu_op_pkg::PREC_SINGLE;
    dp = fpu_op_pkg::PREC_DOUBLE;
    minmax_case(fmin, dp, 64'h3FF0_0000_0000_0000, 64'h4000_0000_0000_0000,
                64'h3FF0_0000_0000_0000, 1'b0);
    minmax_case(fmin, dp, 64'h4000_0000_0000_0000, 64'h3FF0_0000_0000_0000,
                64'h3FF0_0000_0000_0000, 1'b0);
    minmax_case(fmax, dp, 64'h3FF0_0000_0000_0000, 64'h4000_0000_0000_0000,
                64'h4000_0000_0000_0000, 1'b0);
    minmax_case(fmax, dp, 64'h4000_0000_0000_0000, 64'h3FF0_0000_0000_0000,
                64'h4000_0000_0000_0000, 1'b0);
    minmax_case(fmin, dp, 64'hBFF0_0000_0000_0000, 64'hC000_0000_0000_0000,
                64'hC000_0000_0000_0000, 1'b0);
    minmax_case(fmin, dp, 64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000,
                64'h8000_0000_0000_0000, 1'b0);
    minmax_case(fmax, dp, 64'h8000_0000_0000_0000, 64'h0000_0000_0000_0000,
                64'h0000_0000_0000_0000, 1'b0);
    minmax_case(fmin, dp, 64'h7FF8_0000_0000_1234, 64'h3FF0_0000_0000_0000,
                64'h3FF0_0000_0000_0000, 1'b0);
    minmax_case(fmax, dp, 64'h3FF0_0000_0000_0000, 64'h7FF8_0000_0000_1234,
                64'h3FF0_0000_0000_0000, 1'b0);
    minmax_case(fmax, dp, 64'h7FF8_0000_0000_1234, 64'hFFF8_0000_0000_0042,
                64'h7FF8_0000_0000_0000, 1'b0);
    minmax_case(fmin, sp, 64'h0000_0000_3F80_0000, 64'hFFFF_FFFF_7FC0_1234,
                64'hFFFF_FFFF_7FC0_0000, 1'b0);
    minmax_case(fmin, dp, 64'h7FF0_0000_0000_0001, 64'h3FF0_0000_0000_0000,
                64'h3FF0_0000_0000_0000, 1'b1);
    minmax_case(fmax, sp, 64'hFFFF_FFFF_3F80_0000, 64'hFFFF_FFFF_7F80_0001,
                64'hFFFF_FFFF_3F80_0000, 1'b1);
    minmax_case(fmin, sp, 64'hFFFF_FFFF_3F80_0000, 64'hFFFF_FFFF_4000_0000,
                64'hFFFF_FFFF_3F80_0000, 1'b0);
endtask

// File: testbench/tb_fp_misc_unit.sv
`timescale 1ns/1ps

module tb_fp_misc_unit;

    localparam int TIMEOUT_CYCLES = 400;             // About 100 requests of 3 cycles each.

    logic                 clk;
    logic                 rst_n;
    logic                 req;
    fpu_op_pkg::fpu_req_t req_data;
    logic                 ack;
    fpu_op_pkg::fpu_rsp_t rsp_data;

    logic [15:0]          lfsr_state;
    int                   cycle_count;
    int                   check_count;
    int                   mismatch_count;

    fp_misc_unit i_fp_misc_unit
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data)
    );

    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Timeout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles: the DUT stopped answering requests.",
                     cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random operands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        if (state[0])
            next = (state >> 1) ^ 16'hB400;          // Taps 16, 14, 13 and 11.
        else
            next = state >> 1;
        return next;
    endfunction

    task automatic random_word(output fp_format_pkg::fp_word_t word);
        word = '0;
        repeat (64)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            word = {word[62:0], lfsr_state[0]};
        end
    endtask

    `include "tb_fp_misc_tasks.svh"

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial
    begin
        clk = 1'b0;
        rst_n = 1'b0;
        req = 1'b0;
        req_data = '0;
        lfsr_state = 16'd57497;
        cycle_count = 0;
        check_count = 0;
        mismatch_count = 0;
        repeat (8) @(posedge clk);
        #5;
        rst_n = 1'b1;
        test_handshake();
        test_classification();
        test_nan_boxing();
        test_sign_injection();
        test_min_max();
        $display("Checks run: %0d, mismatches: %0d", check_count, mismatch_count);
        if (mismatch_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: hdl/fp_misc_unit.sv
`timescale 1ns/1ps

module fp_misc_unit
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req,
    input  fpu_op_pkg::fpu_req_t req_data,
    output logic                 ack,
    output fpu_op_pkg::fpu_rsp_t rsp_data
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        CALC = 2'd1,
        RESP = 2'd2
    } state_e;

    state_e                      state;
    fpu_op_pkg::fpu_req_t        req_q;
    fpu_op_pkg::fpu_rsp_t        rsp_next;

    fp_format_pkg::fp_unpacked_t operand_rs1;
    fp_format_pkg::fp_unpacked_t operand_rs2;
    fp_format_pkg::fp_class_t    class_rs1;
    fp_format_pkg::fp_class_t    class_rs2;
    fp_format_pkg::fp_word_t     sgnj_result;
    fp_format_pkg::fp_word_t     minmax_result;
    logic                        minmax_nv;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
            ack <= 1'b0;
            rsp_data <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (req)
                        state <= CALC;
                end
                CALC:
                begin
                    rsp_data <= rsp_next;
                    ack <= 1'b1;
                    state <= RESP;
                end
                RESP:
                begin
                    if (!req)                            // Requester has taken the result.
                    begin
                        ack <= 1'b0;
                        state <= IDLE;
                    end
                end
                default:
                begin
                    ack <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && req)
            req_q <= req_data;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fp_operand_unpack i_unpack_rs1
    (
        .word    (req_q.rs1),
        .prec    (req_q.prec),
        .operand (operand_rs1)
    );

    fp_operand_unpack i_unpack_rs2
    (
        .word    (req_q.rs2),
        .prec    (req_q.prec),
        .operand (operand_rs2)
    );

    fp_classify i_classify_rs1
    (
        .operand  (operand_rs1),
        .fp_class (class_rs1)
    );

    fp_classify i_classify_rs2
    (
        .operand  (operand_rs2),
        .fp_class (class_rs2)
    );

    fp_sign_inject i_sign_inject
    (
        .op     (req_q.op),
        .rs1    (operand_rs1),
        .rs2    (operand_rs2),
        .result (sgnj_result)
    );

    fp_min_max i_min_max
    (
        .select_max (req_q.op == fpu_op_pkg::OP_FMAX),
        .rs1        (operand_rs1),
        .rs2        (operand_rs2),
        .class_rs1  (class_rs1),
        .class_rs2  (class_rs2),
        .result     (minmax_result),
        .nv         (minmax_nv)
    );

    always_comb
    begin
        rsp_next.nv = 1'b0;
        case (req_q.op)
            fpu_op_pkg::OP_FCLASS:
            begin
                rsp_next.result = {
                    {(fp_format_pkg::FP_WORD_WIDTH - fp_format_pkg::CLASS_WIDTH){1'b0}},
                    class_rs1
                };
            end
            fpu_op_pkg::OP_FSGNJ, fpu_op_pkg::OP_FSGNJN, fpu_op_pkg::OP_FSGNJX:
            begin
                rsp_next.result = sgnj_result;
            end
            fpu_op_pkg::OP_FMIN, fpu_op_pkg::OP_FMAX:
            begin
                rsp_next.result = minmax_result;
                rsp_next.nv = minmax_nv;                 // Only min/max can flag invalid.
            end
            default:
            begin
                rsp_next.result = '0;
            end
        endcase
    end

endmodule

// File: hdl/fp_min_max.sv
`timescale 1ns/1ps

module fp_min_max
(
    input  logic                        select_max,
    input  fp_format_pkg::fp_unpacked_t rs1,
    input  fp_format_pkg::fp_unpacked_t rs2,
    input  fp_format_pkg::fp_class_t    class_rs1,
    input  fp_format_pkg::fp_class_t    class_rs2,
    output fp_format_pkg::fp_word_t     result,
    output logic                        nv
);

    logic                   rs1_nan;
    logic                   rs2_nan;
    logic                   rs1_less;
    logic                   pick_rs1;
    fp_format_pkg::fp_mag_t mag_rs1;
    fp_format_pkg::fp_mag_t mag_rs2;

    assign rs1_nan = class_rs1[fp_format_pkg::CLASS_SNAN] | class_rs1[fp_format_pkg::CLASS_QNAN];
    assign rs2_nan = class_rs2[fp_format_pkg::CLASS_SNAN] | class_rs2[fp_format_pkg::CLASS_QNAN];

    assign nv = class_rs1[fp_format_pkg::CLASS_SNAN] | class_rs2[fp_format_pkg::CLASS_SNAN];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sign and magnitude compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign mag_rs1 = {rs1.exp, rs1.frac};
    assign mag_rs2 = {rs2.exp, rs2.frac};

    always_comb
    begin
        if (rs1.sign != rs2.sign)
            rs1_less = rs1.sign;                         // Also orders -0 below +0.
        else if (rs1.sign)
            rs1_less = mag_rs1 > mag_rs2;                // Both negative.
        else
            rs1_less = mag_rs1 < mag_rs2;
    end

    assign pick_rs1 = select_max ? ~rs1_less : rs1_less;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        if (rs1_nan && rs2_nan)
        begin
            if (rs1.is_single)
                result = fp_format_pkg::SP_CANONICAL_NAN;
            else
                result = fp_format_pkg::DP_CANONICAL_NAN;
        end
        else if (rs1_nan)
        begin
            result = fp_format_pkg::pack_word(rs2);      // The number wins over a NaN.
        end
        else if (rs2_nan)
        begin
            result = fp_format_pkg::pack_word(rs1);
        end
        else if (pick_rs1)
        begin
            result = fp_format_pkg::pack_word(rs1);
        end
        else
        begin
            result = fp_format_pkg::pack_word(rs2);
        end
    end

endmodule

// File: hdl/fp_sign_inject.sv
`timescale 1ns/1ps

module fp_sign_inject
(
    input  fpu_op_pkg::fp_op_e          op,
    input  fp_format_pkg::fp_unpacked_t rs1,
    input  fp_format_pkg::fp_unpacked_t rs2,
    output fp_format_pkg::fp_word_t     result
);

    logic                        new_sign;
    fp_format_pkg::fp_unpacked_t injected;

    always_comb
    begin
        case (op)
            fpu_op_pkg::OP_FSGNJ:
            begin
                new_sign = rs2.sign;
            end
            fpu_op_pkg::OP_FSGNJN:
            begin
                new_sign = ~rs2.sign;
            end
            fpu_op_pkg::OP_FSGNJX:
            begin
                new_sign = rs1.sign ^ rs2.sign;
            end
            default:
            begin
                new_sign = rs1.sign;                     // Not a sign-injection op.
            end
        endcase
    end

    // Exponent, fraction and precision come from rs1.
    always_comb
    begin
        injected = rs1;
        injected.sign = new_sign;
    end

    assign result = fp_format_pkg::pack_word(injected);

endmodule

// File: hdl/fp_classify.sv
`timescale 1ns/1ps

module fp_classify
(
    input  fp_format_pkg::fp_unpacked_t operand,
    output fp_format_pkg::fp_class_t    fp_class
);

    logic exp_zero;
    logic exp_ones;
    logic frac_zero;
    logic frac_msb;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        if (operand.is_single)
        begin
            exp_zero = ~|operand.exp[fp_format_pkg::SP_EXP_WIDTH-1:0];
            exp_ones = &operand.exp[fp_format_pkg::SP_EXP_WIDTH-1:0];
            frac_zero = ~|operand.frac[fp_format_pkg::SP_FRAC_WIDTH-1:0];
            frac_msb = operand.frac[fp_format_pkg::SP_FRAC_WIDTH-1]; // Quiet bit.
        end
        else
        begin
            exp_zero = ~|operand.exp;
            exp_ones = &operand.exp;
            frac_zero = ~|operand.frac;
            frac_msb = operand.frac[fp_format_pkg::DP_FRAC_WIDTH-1];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One-hot class decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        fp_class = '0;
        if (exp_ones)
        begin
            if (frac_zero)
            begin
                if (operand.sign)
                    fp_class[fp_format_pkg::CLASS_NEG_INF] = 1'b1;
                else
                    fp_class[fp_format_pkg::CLASS_POS_INF] = 1'b1;
            end
            else if (frac_msb)
                fp_class[fp_format_pkg::CLASS_QNAN] = 1'b1;
            else
                fp_class[fp_format_pkg::CLASS_SNAN] = 1'b1; // NaN sign is ignored.
        end
        else if (exp_zero)
        begin
            if (frac_zero)
            begin
                if (operand.sign)
                    fp_class[fp_format_pkg::CLASS_NEG_ZERO] = 1'b1;
                else
                    fp_class[fp_format_pkg::CLASS_POS_ZERO] = 1'b1;
            end
            else if (operand.sign)
                fp_class[fp_format_pkg::CLASS_NEG_SUBNORMAL] = 1'b1;
            else
                fp_class[fp_format_pkg::CLASS_POS_SUBNORMAL] = 1'b1;
        end
        else if (operand.sign)
            fp_class[fp_format_pkg::CLASS_NEG_NORMAL] = 1'b1;
        else
            fp_class[fp_format_pkg::CLASS_POS_NORMAL] = 1'b1;
    end

endmodule

// File: hdl/fp_operand_unpack.sv
`timescale 1ns/1ps

module fp_operand_unpack
(
    input  fp_format_pkg::fp_word_t     word,
    input  fpu_op_pkg::fp_prec_e        prec,
    output fp_format_pkg::fp_unpacked_t operand
);

    logic                    boxed;
    fp_format_pkg::fp_word_t sp_word;

    // A single value must carry all ones in the upper half.
    assign boxed = &word[fp_format_pkg::FP_WORD_WIDTH-1:fp_format_pkg::SP_SIGN_BIT+1];
    assign sp_word = boxed ? word : fp_format_pkg::SP_CANONICAL_NAN;

    always_comb
    begin
        if (prec == fpu_op_pkg::PREC_DOUBLE)
        begin
            operand.sign = word[fp_format_pkg::DP_SIGN_BIT];
            operand.exp = word[fp_format_pkg::DP_SIGN_BIT-1:fp_format_pkg::DP_FRAC_WIDTH];
            operand.frac = word[fp_format_pkg::DP_FRAC_WIDTH-1:0];
            operand.is_single = 1'b0;
        end
        else
        begin
            operand.sign = sp_word[fp_format_pkg::SP_SIGN_BIT];
            operand.exp = {
                {(fp_format_pkg::DP_EXP_WIDTH - fp_format_pkg::SP_EXP_WIDTH){1'b0}},
                sp_word[fp_format_pkg::SP_SIGN_BIT-1:fp_format_pkg::SP_FRAC_WIDTH]
            };                                           // Zero-extended exponent.
            operand.frac = {
                {(fp_format_pkg::DP_FRAC_WIDTH - fp_format_pkg::SP_FRAC_WIDTH){1'b0}},
                sp_word[fp_format_pkg::SP_FRAC_WIDTH-1:0]
            };                                           // Zero-extended fraction.
            operand.is_single = 1'b1;
        end
    end

endmodule

// File: hdl/fpu_op_pkg.sv
package fpu_op_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operations and precision
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        OP_FCLASS = 3'd0,
        OP_FSGNJ  = 3'd1,
        OP_FSGNJN = 3'd2,
        OP_FSGNJX = 3'd3,
        OP_FMIN   = 3'd4,
        OP_FMAX   = 3'd5
    } fp_op_e;

    typedef enum logic {
        PREC_SINGLE = 1'b0,
        PREC_DOUBLE = 1'b1
    } fp_prec_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request and response
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        fp_op_e                  op;
        fp_prec_e                prec;
        fp_format_pkg::fp_word_t rs1;
        fp_format_pkg::fp_word_t rs2;
    } fpu_req_t;

    typedef struct packed {
        fp_format_pkg::fp_word_t result;
        logic                    nv;     // Invalid operation.
    } fpu_rsp_t;

endpackage

// File: hdl/fp_format_pkg.sv
package fp_format_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int FP_WORD_WIDTH = 64;
    localparam int DP_EXP_WIDTH = 11;
    localparam int DP_FRAC_WIDTH = 52;
    localparam int SP_EXP_WIDTH = 8;
    localparam int SP_FRAC_WIDTH = 23;
    localparam int DP_SIGN_BIT = DP_EXP_WIDTH + DP_FRAC_WIDTH; // Bit 63 of the register word.
    localparam int SP_SIGN_BIT = SP_EXP_WIDTH + SP_FRAC_WIDTH; // Bit 31 of the register word.
    localparam int CLASS_WIDTH = 10;

    typedef logic [FP_WORD_WIDTH-1:0] fp_word_t;
    typedef logic [DP_EXP_WIDTH-1:0] fp_exp_t;
    typedef logic [DP_FRAC_WIDTH-1:0] fp_frac_t;
    typedef logic [DP_EXP_WIDTH+DP_FRAC_WIDTH-1:0] fp_mag_t; // Exponent and fraction together.
    typedef logic [CLASS_WIDTH-1:0] fp_class_t;

    // Single fields sit in the low bits; upper bits are zero.
    typedef struct packed {
        logic     sign;
        fp_exp_t  exp;
        fp_frac_t frac;
        logic     is_single;
    } fp_unpacked_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Class mask bit positions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int CLASS_NEG_INF = 0;
    localparam int CLASS_NEG_NORMAL = 1;
    localparam int CLASS_NEG_SUBNORMAL = 2;
    localparam int CLASS_NEG_ZERO = 3;
    localparam int CLASS_POS_ZERO = 4;
    localparam int CLASS_POS_SUBNORMAL = 5;
    localparam int CLASS_POS_NORMAL = 6;
    localparam int CLASS_POS_INF = 7;
    localparam int CLASS_SNAN = 8;
    localparam int CLASS_QNAN = 9;

    localparam fp_word_t SP_CANONICAL_NAN = 64'hFFFF_FFFF_7FC0_0000; // NaN-boxed.
    localparam fp_word_t DP_CANONICAL_NAN = 64'h7FF8_0000_0000_0000;

    // Repacks an unpacked value into a register word, NaN-boxing single results.
    function automatic fp_word_t pack_word(input fp_unpacked_t value);
        fp_word_t word;
        if (value.is_single)
            word = {32'hFFFF_FFFF, value.sign, value.exp[SP_EXP_WIDTH-1:0],
                    value.frac[SP_FRAC_WIDTH-1:0]};
        else
            word = {value.sign, value.exp, value.frac};
        return word;
    endfunction

endpackage
